/* common/i2cApbPkg.sv */
package i2cApbPkg;

    // bus and register widths
    localparam int addrWidth   = 16;
    localparam int wordWidth   = 32;
    localparam int regWidth    = 16;
    localparam int offsetWidth = 4;

    // word offset sits just above the two byte-lane bits
    localparam int offsetLsb = 2;

    // upper address nibble picks the bank
    localparam int regionMsb = 15;
    localparam int regionLsb = 12;

    typedef logic [addrWidth-1:0]   apbAddr_t;
    typedef logic [wordWidth-1:0]   word_t;
    typedef logic [regWidth-1:0]    regWord_t;
    typedef logic [offsetWidth-1:0] regOffset_t;

    // incoming APB3 request, flat ports packed together
    typedef struct packed {
        apbAddr_t paddr;
        logic     psel;
        logic     penable;
        logic     pwrite;
        word_t    pwdata;
    } apbReq_t;

    // request as seen by one register bank
    // sel already includes the region match
    typedef struct packed {
        regOffset_t offset;
        logic       sel;
        logic       enable;
        logic       write;
        regWord_t   wdata;
    } bankReq_t;

    // CR1 layout
    typedef struct packed {
        // bits 15..11
        logic [4:0] rsvdHi;
        // acknowledge enable
        logic       ack;
        // stop request, self-clearing
        logic       stop;
        // start request, self-clearing
        logic       start;
        // bits 7..1
        logic [6:0] rsvdLo;
        // peripheral enable
        logic       pe;
    } cr1_t;

    // register word offsets
    localparam regOffset_t offCr1   = 4'd0;
    localparam regOffset_t offCr2   = 4'd1;
    localparam regOffset_t offOar1  = 4'd2;
    localparam regOffset_t offOar2  = 4'd3;
    localparam regOffset_t offDr    = 4'd4;
    localparam regOffset_t offSr1   = 4'd5;
    localparam regOffset_t offSr2   = 4'd6;
    localparam regOffset_t offCcr   = 4'd7;
    localparam regOffset_t offTrise = 4'd8;

    // start-bit flag position in SR1
    localparam int sr1SbBit = 0;

endpackage

/* i2cRegBank/i2cRegBank.sv */
module i2cRegBank
    import i2cApbPkg::*;
(
    input  logic     io_apb_PCLK,
    input  logic     io_apb_PRESET,
    input  bankReq_t bankReq,
    output word_t    rdata
);

    // control register 1 with named fields
    cr1_t     cr1;
    // control register 2
    regWord_t cr2;
    // own address registers
    regWord_t oar1;
    regWord_t oar2;
    // data register
    regWord_t dr;
    // clock control
    regWord_t ccr;
    // rise time
    regWord_t trise;

    // start condition flag is the only live status bit
    logic     sb;

    // derived status word
    regWord_t sr1;

    // access-phase qualifiers
    logic     accessPhase;
    logic     wrEn;
    logic     rdEn;
    // SR1 read in the access phase clears sb
    logic     sr1Read;

    // selected register before zero-extension
    regWord_t rdWord;

    assign accessPhase = bankReq.sel && bankReq.enable;
    assign wrEn        = accessPhase && bankReq.write;
    assign rdEn        = accessPhase && !bankReq.write;
    assign sr1Read     = rdEn && (bankReq.offset == offSr1);

    // CR1
    // start and stop drop back to zero one cycle after being set
    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            cr1 <= '0;
        end else if (wrEn && (bankReq.offset == offCr1)) begin
            // full word write with start and stop as written
            cr1 <= cr1_t'(bankReq.wdata);
        end else begin
            // start and stop self-clear while other fields hold
            cr1.start <= 1'b0;
            cr1.stop  <= 1'b0;
        end
    end

    // plain read/write config registers
    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            cr2   <= '0;
            oar1  <= '0;
            oar2  <= '0;
            dr    <= '0;
            ccr   <= '0;
            trise <= '0;
        end else if (wrEn) begin
            case (bankReq.offset)
                offCr2:   cr2   <= bankReq.wdata;
                offOar1:  oar1  <= bankReq.wdata;
                offOar2:  oar2  <= bankReq.wdata;
                offDr:    dr    <= bankReq.wdata;
                offCcr:   ccr   <= bankReq.wdata;
                offTrise: trise <= bankReq.wdata;
                // status words and unmapped offsets are read-only
                default: ;
            endcase
        end
    end

    // SB flag
    // set on any selected cycle and cleared by an SR1 access-phase read
    // clear wins when both happen on the same edge
    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            sb <= 1'b0;
        end else if (sr1Read) begin
            sb <= 1'b0;
        end else if (bankReq.sel) begin
            sb <= 1'b1;
        end
    end

    // SR1 carries sb and nothing else
    always_comb begin
        sr1           = '0;
        sr1[sr1SbBit] = sb;
    end

    // read mux
    always_comb begin
        case (bankReq.offset)
            offCr1:   rdWord = regWord_t'(cr1);
            offCr2:   rdWord = cr2;
            offOar1:  rdWord = oar1;
            offOar2:  rdWord = oar2;
            offDr:    rdWord = dr;
            offSr1:   rdWord = sr1;
            // SR2 has no live bits
            offSr2:   rdWord = '0;
            offCcr:   rdWord = ccr;
            offTrise: rdWord = trise;
            // offsets 9 to 15 hold nothing
            default:  rdWord = '0;
        endcase
    end

    // zero-extend to the bus word
    // driven only during an access-phase read
    assign rdata = rdEn ? {{(wordWidth - regWidth){1'b0}}, rdWord} : '0;

endmodule

/* rtl/apbRouter.sv */
module apbRouter
    import i2cApbPkg::*;
#(
    parameter int bankCount = 2
) (
    input  logic                     io_apb_PCLK,
    input  logic                     io_apb_PRESET,
    input  apbReq_t                  apbReq,
    output bankReq_t [bankCount-1:0] bankReqs,
    input  word_t    [bankCount-1:0] bankRdata,
    output logic                     pready,
    output word_t                    prdata,
    output logic                     pslverror
);

    localparam int regionWidth = regionMsb - regionLsb + 1;

    // region nibble of the current address
    logic [regionWidth-1:0] region;
    // combinational bank hit, psel included
    logic [bankCount-1:0]   bankHit;
    // psel high but no bank claims the region
    logic                   unmappedHit;
    // select captured at each edge, used in the access phase
    logic [bankCount-1:0]   selReg;
    logic                   unmappedReg;
    // psel and penable both high
    logic                   accessPhase;
    // read word of the registered bank
    word_t                  muxData;

    assign region = apbReq.paddr[regionMsb:regionLsb];

    // per-bank decode and request fan-out
    for (genvar i = 0; i < bankCount; i++) begin : bankDecode
        assign bankHit[i] = apbReq.psel && (region == regionWidth'(i));

        // bank only sees its word offset and low data half
        assign bankReqs[i] = '{
            offset: apbReq.paddr[offsetLsb +: offsetWidth],
            sel:    bankHit[i],
            enable: apbReq.penable,
            write:  apbReq.pwrite,
            wdata:  apbReq.pwdata[regWidth-1:0]
        };
    end

    // nothing hit while selected means an unmapped region
    assign unmappedHit = apbReq.psel && !(|bankHit);

    // select register, loaded every clock
    // value from the setup edge steers the access phase
    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            selReg      <= '0;
            unmappedReg <= 1'b0;
        end else begin
            selReg      <= bankHit;
            unmappedReg <= unmappedHit;
        end
    end

    assign accessPhase = apbReq.psel && apbReq.penable;

    // one-hot select, so an OR of the gated words is enough
    always_comb begin
        muxData = '0;
        for (int i = 0; i < bankCount; i++) begin
            if (selReg[i]) begin
                muxData = muxData | bankRdata[i];
            end
        end
    end

    // no wait states
    assign pready = 1'b1;

    // read data only while the access cycle is on the bus
    assign prdata = accessPhase ? muxData : '0;

    // error for reads and writes to an unmapped region
    assign pslverror = accessPhase && unmappedReg;

endmodule

/* rtl/apb3I2cRouter.sv */
module apb3I2cRouter
    import i2cApbPkg::*;
#(
    parameter int bankCount = 2
) (
    input  logic     io_apb_PCLK,
    input  logic     io_apb_PRESET,
    input  apbAddr_t io_apb_PADDR,
    input  logic     io_apb_PSEL,
    input  logic     io_apb_PENABLE,
    input  logic     io_apb_PWRITE,
    input  word_t    io_apb_PWDATA,
    output logic     io_apb_PREADY,
    output word_t    io_apb_PRDATA,
    output logic     io_apb_PSLVERROR
);

    // flat APB inputs gathered into one request
    apbReq_t                 apbReq;
    // per-bank requests and read words
    bankReq_t [bankCount-1:0] bankReqs;
    word_t    [bankCount-1:0] bankRdata;

    assign apbReq = '{
        paddr:   io_apb_PADDR,
        psel:    io_apb_PSEL,
        penable: io_apb_PENABLE,
        pwrite:  io_apb_PWRITE,
        pwdata:  io_apb_PWDATA
    };

    // region decode and response mux
    apbRouter #(
        .bankCount(bankCount)
    ) router (
        .io_apb_PCLK  (io_apb_PCLK),
        .io_apb_PRESET(io_apb_PRESET),
        .apbReq       (apbReq),
        .bankReqs     (bankReqs),
        .bankRdata    (bankRdata),
        .pready       (io_apb_PREADY),
        .prdata       (io_apb_PRDATA),
        .pslverror    (io_apb_PSLVERROR)
    );

    // one register bank per region, bank i at region nibble i
    for (genvar i = 0; i < bankCount; i++) begin : bankGen
        i2cRegBank i2cBank (
            .io_apb_PCLK  (io_apb_PCLK),
            .io_apb_PRESET(io_apb_PRESET),
            .bankReq      (bankReqs[i]),
            .rdata        (bankRdata[i])
        );
    end

endmodule

/* test/clockGen.sv */
module clockGen #(
    parameter int resetCycles = 4
) (
    output logic io_apb_PCLK,
    output logic io_apb_PRESET
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    localparam int halfPeriodNs = 50;

    initial begin
        io_apb_PCLK = 1'b0;
        forever #(halfPeriodNs) io_apb_PCLK = ~io_apb_PCLK;
    end

    // reset held over the first few rising edges
    // released just after the last one
    initial begin
        io_apb_PRESET = 1'b1;
        repeat (resetCycles) @(posedge io_apb_PCLK);
        #1;
        io_apb_PRESET = 1'b0;
    end

endmodule

/* test/tbApb3I2cRouter.sv */
module tbApb3I2cRouter
    import i2cApbPkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriodNs   = 100;
    localparam int resetCycles   = 4;
    localparam int cyclesPerXfer = 3;
    localparam int marginCycles  = 20;

    // one table row with its name kept in a parallel queue
    typedef struct packed {
        logic     isWrite;
        apbAddr_t addr;
        word_t    wdata;
        word_t    expRdata;
        logic     expErr;
    } stimEntry_t;

    logic     io_apb_PCLK;
    logic     io_apb_PRESET;
    apbAddr_t io_apb_PADDR;
    logic     io_apb_PSEL;
    logic     io_apb_PENABLE;
    logic     io_apb_PWRITE;
    word_t    io_apb_PWDATA;
    logic     io_apb_PREADY;
    word_t    io_apb_PRDATA;
    logic     io_apb_PSLVERROR;

    stimEntry_t stimTable[$];
    string      stimNames[$];
    // expected register contents per bank and offset
    regWord_t   shadow [2][16];
    logic       tableReady = 1'b0;
    longint     timeoutNs;

    clockGen #(
        .resetCycles(resetCycles)
    ) clkGen (
        .io_apb_PCLK  (io_apb_PCLK),
        .io_apb_PRESET(io_apb_PRESET)
    );

    apb3I2cRouter UUT (
        .io_apb_PCLK     (io_apb_PCLK),
        .io_apb_PRESET   (io_apb_PRESET),
        .io_apb_PADDR    (io_apb_PADDR),
        .io_apb_PSEL     (io_apb_PSEL),
        .io_apb_PENABLE  (io_apb_PENABLE),
        .io_apb_PWRITE   (io_apb_PWRITE),
        .io_apb_PWDATA   (io_apb_PWDATA),
        .io_apb_PREADY   (io_apb_PREADY),
        .io_apb_PRDATA   (io_apb_PRDATA),
        .io_apb_PSLVERROR(io_apb_PSLVERROR)
    );

    function automatic string regName(input int offset);
        case (offset)
            0: return "CR1";
            1: return "CR2";
            2: return "OAR1";
            3: return "OAR2";
            4: return "DR";
            5: return "SR1";
            6: return "SR2";
            7: return "CCR";
            8: return "TRISE";
            default: return $sformatf("OFF%0d", offset);
        endcase
    endfunction

    // region nibble on top and word offset at bits 5..2
    function automatic apbAddr_t makeAddr(input int region, input int offset);
        return apbAddr_t'((region << 12) | (offset << 2));
    endfunction

    // read value the register map should give
    function automatic word_t expectedRead(input int region, input int offset);
        if (region >= 2) begin
            return '0;
        end
        case (offset)
            // setup phase of the same read always sets SB
            5: return 32'h0000_0001;
            0, 1, 2, 3, 4, 7, 8: return {16'h0000, shadow[region][offset]};
            default: return '0;
        endcase
    endfunction

    task automatic addWrite(input string name, input int region, input int offset,
                            input word_t data);
        stimEntry_t entry;
        entry.isWrite  = 1'b1;
        entry.addr     = makeAddr(region, offset);
        entry.wdata    = data;
        // nothing driven back on a write
        entry.expRdata = '0;
        entry.expErr   = (region >= 2);
        stimTable.push_back(entry);
        stimNames.push_back(name);
        if (region < 2) begin
            case (offset)
                // start and stop already self-cleared by any later read
                0: shadow[region][offset] = data[15:0] & ~16'h0300;
                1, 2, 3, 4, 7, 8: shadow[region][offset] = data[15:0];
                default: ;
            endcase
        end
    endtask

    task automatic addRead(input string name, input int region, input int offset);
        stimEntry_t entry;
        entry.isWrite  = 1'b0;
        entry.addr     = makeAddr(region, offset);
        entry.wdata    = '0;
        entry.expRdata = expectedRead(region, offset);
        entry.expErr   = (region >= 2);
        stimTable.push_back(entry);
        stimNames.push_back(name);
    endtask

    task automatic buildTable();
        int rwOffsets[6] = '{1, 2, 3, 4, 7, 8};
        int roOffsets[5] = '{5, 6, 9, 12, 15};
        for (int b = 0; b < 2; b++) begin
            for (int o = 0; o < 16; o++) begin
                shadow[b][o] = '0;
            end
        end
        // reset values
        for (int b = 0; b < 2; b++) begin
            for (int o = 0; o < 9; o++) begin
                addRead($sformatf("reset b%0d %s", b, regName(o)), b, o);
            end
        end
        // random words into the plain registers of both banks
        for (int b = 0; b < 2; b++) begin
            foreach (rwOffsets[k]) begin
                addWrite($sformatf("wr b%0d %s", b, regName(rwOffsets[k])),
                         b, rwOffsets[k], $urandom());
            end
            foreach (roOffsets[k]) begin
                addWrite($sformatf("wr ro b%0d %s", b, regName(roOffsets[k])),
                         b, roOffsets[k], $urandom());
            end
        end
        // full readback including empty offsets
        for (int b = 0; b < 2; b++) begin
            for (int o = 0; o < 16; o++) begin
                addRead($sformatf("rd b%0d %s", b, regName(o)), b, o);
            end
        end
        // CR1 with start and stop forced high
        for (int b = 0; b < 2; b++) begin
            addWrite($sformatf("cr1 start b%0d", b), b, 0, $urandom() | 32'h0000_0300);
            addRead($sformatf("cr1 clear b%0d", b), b, 0);
        end
        // same offset in independent banks
        addWrite("iso wr b0 DR", 0, 4, $urandom());
        addRead("iso rd b1 DR", 1, 4);
        addWrite("iso wr b1 DR", 1, 4, $urandom());
        addRead("iso rd b0 DR", 0, 4);
        addRead("iso rd b1 DR again", 1, 4);
        // SB comes back with each setup phase
        addRead("sr1 first b1", 1, 5);
        addRead("sr1 second b1", 1, 5);
        addRead("sr1 first b0", 0, 5);
        addRead("sr1 second b0", 0, 5);
        // unmapped regions
        addWrite("unmapped wr r2 DR", 2, 4, $urandom());
        addRead("unmapped rd r2 DR", 2, 4);
        addWrite("unmapped wr r15 CR2", 15, 1, $urandom());
        addRead("unmapped rd r15 CR2", 15, 1);
        for (int b = 0; b < 2; b++) begin
            addRead($sformatf("after unmapped b%0d DR", b), b, 4);
            addRead($sformatf("after unmapped b%0d CR2", b), b, 1);
        end
    endtask

    // setup and access phase followed by one idle cycle
    task automatic apbTransfer(input stimEntry_t entry, output word_t rdata,
                               output logic err, output logic ready);
        @(posedge io_apb_PCLK);
        #1;
        io_apb_PADDR   = entry.addr;
        io_apb_PWRITE  = entry.isWrite;
        io_apb_PWDATA  = entry.wdata;
        io_apb_PSEL    = 1'b1;
        io_apb_PENABLE = 1'b0;
        @(posedge io_apb_PCLK);
        #1;
        io_apb_PENABLE = 1'b1;
        // response settled by mid access cycle
        @(negedge io_apb_PCLK);
        rdata = io_apb_PRDATA;
        err   = io_apb_PSLVERROR;
        ready = io_apb_PREADY;
        @(posedge io_apb_PCLK);
        #1;
        io_apb_PSEL    = 1'b0;
        io_apb_PENABLE = 1'b0;
    endtask

    task automatic checkValue(input string testName, input word_t expected,
                              input word_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h",
                     testName, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    initial begin
        word_t rdata;
        logic  err;
        logic  ready;
        io_apb_PADDR   = '0;
        io_apb_PSEL    = 1'b0;
        io_apb_PENABLE = 1'b0;
        io_apb_PWRITE  = 1'b0;
        io_apb_PWDATA  = '0;
        void'($urandom(6));
        buildTable();
        tableReady = 1'b1;
        @(negedge io_apb_PRESET);
        for (int i = 0; i < stimTable.size(); i++) begin
            apbTransfer(stimTable[i], rdata, err, ready);
            checkValue({stimNames[i], " PRDATA"}, stimTable[i].expRdata, rdata);
            checkValue({stimNames[i], " PSLVERROR"}, 32'(stimTable[i].expErr), 32'(err));
            checkValue({stimNames[i], " PREADY"}, 32'd1, 32'(ready));
        end
        $display("Testbench passed");
        $finish;
    end

    // limit scales with the table length
    initial begin
        wait (tableReady);
        timeoutNs = longint'(resetCycles + cyclesPerXfer * stimTable.size() + marginCycles)
                    * clkPeriodNs;
        #(timeoutNs);
        $display("Timeout: the transfers did not finish within %0d ns", timeoutNs);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* compile.f */
common/i2cApbPkg.sv
i2cRegBank/i2cRegBank.sv
rtl/apbRouter.sv
rtl/apb3I2cRouter.sv
test/clockGen.sv
test/tbApb3I2cRouter.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f compile.f --top-module tbApb3I2cRouter \
    && ./obj_dir/VtbApb3I2cRouter | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
